// File: hdl/wiscExec_defines.svh
// Global macros for the WISC-SP20 execute unit
// Word width and register count
// Opcode values, ALU function codes and result-select codes
`ifndef WISC_EXEC_DEFINES_SVH
`define WISC_EXEC_DEFINES_SVH

`define WISC_WORD_WIDTH 16
`define WISC_REG_COUNT  8

// Opcodes in instr[15:11]
`define WISC_OP_ADDI   5'b01000
`define WISC_OP_SUBI   5'b01001
`define WISC_OP_XORI   5'b01010
`define WISC_OP_ANDNI  5'b01011
`define WISC_OP_ROLI   5'b10100
`define WISC_OP_SLLI   5'b10101
`define WISC_OP_RORI   5'b10110
`define WISC_OP_SRLI   5'b10111
`define WISC_OP_SLBI   5'b10010
`define WISC_OP_LBI    5'b11000
`define WISC_OP_BTR    5'b11001
`define WISC_OP_RSHIFT 5'b11010
`define WISC_OP_RALU   5'b11011
`define WISC_OP_SEQ    5'b11100
`define WISC_OP_SLT    5'b11101
`define WISC_OP_SLE    5'b11110
`define WISC_OP_SCO    5'b11111

// ALU functions
`define WISC_FN_ADD  3'd0
`define WISC_FN_XOR  3'd1
`define WISC_FN_ANDN 3'd2
`define WISC_FN_ROL  3'd3
`define WISC_FN_SLL  3'd4
`define WISC_FN_ROR  3'd5
`define WISC_FN_SRL  3'd6

// Result selects; ILL tags an illegal opcode
`define WISC_SEL_ALU 3'd0
`define WISC_SEL_EQ  3'd1
`define WISC_SEL_LT  3'd2
`define WISC_SEL_LE  3'd3
`define WISC_SEL_CO  3'd4
`define WISC_SEL_BTR 3'd5
`define WISC_SEL_ILL 3'd6

`endif

// File: hdl/wiscExecPkg.sv
// Shared typedefs of the execute unit
// Data word, register number and the decoded control fields
`include "wiscExec_defines.svh"

package wiscExecPkg;

    typedef logic [`WISC_WORD_WIDTH-1:0]         wiscWord;
    typedef logic [$clog2(`WISC_REG_COUNT)-1:0]  regIdx;

    // Instruction and control fields
    typedef logic [4:0] opcodeField;
    typedef logic [2:0] aluFunc;
    typedef logic [2:0] resultSel;

endpackage

// File: hdl/regFile.sv
// Register file of the execute unit
// Eight 16-bit registers, one write port, two write-through read ports
`timescale 1ns/10ps
`include "wiscExec_defines.svh"

module regFile (
    input  logic                 clk,
    input  logic                 arstN,
    input  wiscExecPkg::regIdx   rdAddrA,
    input  wiscExecPkg::regIdx   rdAddrB,
    output wiscExecPkg::wiscWord rdDataA,
    output wiscExecPkg::wiscWord rdDataB,
    input  logic                 wrEn,
    input  wiscExecPkg::regIdx   wrAddr,
    input  wiscExecPkg::wiscWord wrData
);

    wiscExecPkg::wiscWord regs [`WISC_REG_COUNT];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < `WISC_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn) begin
            regs[wrAddr] <= wrData;
        end
    end

    // A write in the same cycle wins over the stored value
    assign rdDataA = (wrEn && wrAddr == rdAddrA) ? wrData : regs[rdAddrA];
    assign rdDataB = (wrEn && wrAddr == rdAddrB) ? wrData : regs[rdAddrB];

endmodule

// File: hdl/decodeStage.sv
// Decode stage of the execute unit
// Opcode decode into ALU, inversion, carry and result-select controls
// Immediate extension, register read and the decode pipeline register
`timescale 1ns/10ps
`include "wiscExec_defines.svh"

module decodeStage (
    input  logic                  clk,
    input  logic                  arstN,
    input  logic                  advance,
    input  logic                  instrValid,
    input  wiscExecPkg::wiscWord  instr,
    output wiscExecPkg::regIdx    rdAddrA,
    output wiscExecPkg::regIdx    rdAddrB,
    input  wiscExecPkg::wiscWord  rdDataA,
    input  wiscExecPkg::wiscWord  rdDataB,
    output logic                  dValid,
    output wiscExecPkg::aluFunc   dFunc,
    output wiscExecPkg::wiscWord  dOperandA,
    output wiscExecPkg::wiscWord  dOperandB,
    output wiscExecPkg::regIdx    dSrcA,
    output wiscExecPkg::regIdx    dSrcB,
    output logic                  dUseRegA,
    output logic                  dUseRegB,
    output logic                  dInvA,
    output logic                  dInvB,
    output logic                  dCin,
    output logic                  dIsLbi,
    output logic                  dIsSlbi,
    output logic                  dIsAddSub,
    output wiscExecPkg::resultSel dResultSel,
    output wiscExecPkg::regIdx    dDest,
    output logic                  dWrites
);

    localparam int ExtWidth5 = `WISC_WORD_WIDTH - 5;
    localparam int ExtWidth8 = `WISC_WORD_WIDTH - 8;

    wiscExecPkg::opcodeField opcode;
    wiscExecPkg::regIdx      rs, rt, rdR, dest;
    wiscExecPkg::wiscWord    imm;
    wiscExecPkg::aluFunc     func;
    wiscExecPkg::resultSel   sel;
    logic useRegA, useRegB, invA, invB, cin, isLbi, isSlbi, isAddSub, writes;

    // Rs is bits 10:8 everywhere; Rt doubles as the I-format destination
    assign opcode  = instr[15:11];
    assign rs      = instr[10:8];
    assign rt      = instr[7:5];
    assign rdR     = instr[4:2];
    assign rdAddrA = rs;
    assign rdAddrB = rt;

    always_comb begin
        func     = `WISC_FN_ADD;
        imm      = {{ExtWidth5{1'b0}}, instr[4:0]};
        useRegA  = 1'b1;
        useRegB  = 1'b0;
        invA     = 1'b0;
        invB     = 1'b0;
        cin      = 1'b0;
        isLbi    = 1'b0;
        isSlbi   = 1'b0;
        isAddSub = 1'b0;
        sel      = `WISC_SEL_ALU;
        dest     = rt;
        writes   = 1'b1;
        case (opcode)
            `WISC_OP_ADDI: begin
                imm      = {{ExtWidth5{instr[4]}}, instr[4:0]};
                isAddSub = 1'b1;
            end
            // imm - Rs as ~Rs + imm + 1
            `WISC_OP_SUBI: begin
                imm      = {{ExtWidth5{instr[4]}}, instr[4:0]};
                invA     = 1'b1;
                cin      = 1'b1;
                isAddSub = 1'b1;
            end
            `WISC_OP_XORI:  func = `WISC_FN_XOR;
            `WISC_OP_ANDNI: func = `WISC_FN_ANDN;
            `WISC_OP_ROLI:  func = `WISC_FN_ROL;
            `WISC_OP_SLLI:  func = `WISC_FN_SLL;
            `WISC_OP_RORI:  func = `WISC_FN_ROR;
            `WISC_OP_SRLI:  func = `WISC_FN_SRL;
            `WISC_OP_RALU: begin
                useRegB = 1'b1;
                dest    = rdR;
                case (instr[1:0])
                    2'b00: isAddSub = 1'b1;
                    2'b01: begin
                        invA     = 1'b1;
                        cin      = 1'b1;
                        isAddSub = 1'b1;
                    end
                    2'b10: func = `WISC_FN_XOR;
                    default: func = `WISC_FN_ANDN;
                endcase
            end
            `WISC_OP_RSHIFT: begin
                useRegB = 1'b1;
                dest    = rdR;
                case (instr[1:0])
                    2'b00: func = `WISC_FN_ROL;
                    2'b01: func = `WISC_FN_SLL;
                    2'b10: func = `WISC_FN_ROR;
                    default: func = `WISC_FN_SRL;
                endcase
            end
            // Compares run Rs - Rt
            `WISC_OP_SEQ, `WISC_OP_SLT, `WISC_OP_SLE: begin
                useRegB = 1'b1;
                dest    = rdR;
                invB    = 1'b1;
                cin     = 1'b1;
                sel     = (opcode == `WISC_OP_SEQ) ? `WISC_SEL_EQ :
                          (opcode == `WISC_OP_SLT) ? `WISC_SEL_LT : `WISC_SEL_LE;
            end
            `WISC_OP_SCO: begin
                useRegB = 1'b1;
                dest    = rdR;
                sel     = `WISC_SEL_CO;
            end
            `WISC_OP_BTR: begin
                dest = rdR;
                sel  = `WISC_SEL_BTR;
            end
            `WISC_OP_LBI: begin
                imm     = {{ExtWidth8{instr[7]}}, instr[7:0]};
                useRegA = 1'b0;
                isLbi   = 1'b1;
                dest    = rs;
            end
            // Low byte of Rs << 8 is zero, so XOR acts as OR
            `WISC_OP_SLBI: begin
                imm    = {{ExtWidth8{1'b0}}, instr[7:0]};
                func   = `WISC_FN_XOR;
                isSlbi = 1'b1;
                dest   = rs;
            end
            default: begin
                useRegA = 1'b0;
                sel     = `WISC_SEL_ILL;
                writes  = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            dValid <= 1'b0;
        end else if (advance) begin
            dValid <= instrValid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            dFunc      <= func;
            dOperandA  <= rdDataA;
            dOperandB  <= useRegB ? rdDataB : imm;
            dSrcA      <= rs;
            dSrcB      <= rt;
            dUseRegA   <= useRegA;
            dUseRegB   <= useRegB;
            dInvA      <= invA;
            dInvB      <= invB;
            dCin       <= cin;
            dIsLbi     <= isLbi;
            dIsSlbi    <= isSlbi;
            dIsAddSub  <= isAddSub;
            dResultSel <= sel;
            dDest      <= dest;
            dWrites    <= writes;
        end
    end

endmodule

// File: hdl/executeStage.sv
// Execute stage of the execute unit
// Operand forwarding from the execute and result registers
// LBI and SLBI operand preparation, the ALU and its flags
// The execute pipeline register
`timescale 1ns/10ps
`include "wiscExec_defines.svh"

module executeStage (
    input  logic                  clk,
    input  logic                  arstN,
    input  logic                  advance,
    input  logic                  dValid,
    input  wiscExecPkg::aluFunc   dFunc,
    input  wiscExecPkg::wiscWord  dOperandA,
    input  wiscExecPkg::wiscWord  dOperandB,
    input  wiscExecPkg::regIdx    dSrcA,
    input  wiscExecPkg::regIdx    dSrcB,
    input  logic                  dUseRegA,
    input  logic                  dUseRegB,
    input  logic                  dInvA,
    input  logic                  dInvB,
    input  logic                  dCin,
    input  logic                  dIsLbi,
    input  logic                  dIsSlbi,
    input  logic                  dIsAddSub,
    input  wiscExecPkg::resultSel dResultSel,
    input  wiscExecPkg::regIdx    dDest,
    input  logic                  dWrites,
    input  wiscExecPkg::wiscWord  finalValue,
    input  logic                  rValid,
    input  wiscExecPkg::regIdx    rDest,
    input  logic                  rWrites,
    input  wiscExecPkg::wiscWord  resData,
    output logic                  eValid,
    output wiscExecPkg::wiscWord  eAluOut,
    output logic                  eZero,
    output logic                  eLtz,
    output logic                  eCarry,
    output logic                  eOvf,
    output wiscExecPkg::wiscWord  eBtrSrc,
    output wiscExecPkg::resultSel eResultSel,
    output logic                  eIsAddSub,
    output wiscExecPkg::regIdx    eDest,
    output logic                  eWrites
);

    localparam int Width = `WISC_WORD_WIDTH;
    localparam int Msb   = Width - 1;

    wiscExecPkg::wiscWord srcA, srcB, aPrep, a, b, aluOut;
    logic [Width:0]       sum;
    logic [2*Width-1:0]   rotL, rotR;
    logic [3:0]           shamt;
    logic                 ovf;

    // Youngest producer first, then the result register, then the decode read
    function automatic wiscExecPkg::wiscWord forward(
        input logic                 useReg,
        input wiscExecPkg::regIdx   src,
        input wiscExecPkg::wiscWord readVal
    );
        if (useReg && eValid && eWrites && eDest == src) begin
            return finalValue;
        end else if (useReg && rValid && rWrites && rDest == src) begin
            return resData;
        end
        return readVal;
    endfunction

    always_comb begin
        srcA = forward(dUseRegA, dSrcA, dOperandA);
        srcB = forward(dUseRegB, dSrcB, dOperandB);
    end

    // LBI adds to zero, SLBI merges the immediate under Rs << 8
    assign aPrep = dIsLbi  ? '0 :
                   dIsSlbi ? (srcA << 8) : srcA;
    assign a     = dInvA ? ~aPrep : aPrep;
    assign b     = dInvB ? ~srcB : srcB;

    assign sum   = {1'b0, a} + {1'b0, b} + dCin;
    assign ovf   = (a[Msb] == b[Msb]) && (sum[Msb] != a[Msb]);
    assign shamt = b[3:0];
    assign rotL  = {a, a} << shamt;
    assign rotR  = {a, a} >> shamt;

    always_comb begin
        case (dFunc)
            `WISC_FN_XOR:  aluOut = a ^ b;
            `WISC_FN_ANDN: aluOut = a & ~b;
            `WISC_FN_ROL:  aluOut = rotL[2*Width-1:Width];
            `WISC_FN_SLL:  aluOut = a << shamt;
            `WISC_FN_ROR:  aluOut = rotR[Msb:0];
            `WISC_FN_SRL:  aluOut = a >> shamt;
            default:       aluOut = sum[Msb:0];
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            eValid <= 1'b0;
        end else if (advance) begin
            eValid <= dValid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            eAluOut    <= aluOut;
            eZero      <= (aluOut == '0);
            // Sign corrected by overflow gives a true signed less-than
            eLtz       <= sum[Msb] ^ ovf;
            eCarry     <= sum[Width];
            eOvf       <= ovf;
            eBtrSrc    <= srcA;
            eResultSel <= dResultSel;
            eIsAddSub  <= dIsAddSub;
            eDest      <= dDest;
            eWrites    <= dWrites;
        end
    end

endmodule

// File: hdl/resultStage.sv
// Result stage of the execute unit
// Set-value, BTR and illegal-opcode selection of the final value
// Error flag, result register and the register-file write request
`timescale 1ns/10ps
`include "wiscExec_defines.svh"

module resultStage (
    input  logic                  clk,
    input  logic                  arstN,
    input  logic                  advance,
    input  logic                  eValid,
    input  wiscExecPkg::wiscWord  eAluOut,
    input  logic                  eZero,
    input  logic                  eLtz,
    input  logic                  eCarry,
    input  logic                  eOvf,
    input  wiscExecPkg::wiscWord  eBtrSrc,
    input  wiscExecPkg::resultSel eResultSel,
    input  logic                  eIsAddSub,
    input  wiscExecPkg::regIdx    eDest,
    input  logic                  eWrites,
    output wiscExecPkg::wiscWord  finalValue,
    output logic                  rValid,
    output wiscExecPkg::regIdx    rDest,
    output logic                  rWrites,
    output logic                  wrEn,
    output wiscExecPkg::regIdx    wrAddr,
    output wiscExecPkg::wiscWord  wrData,
    output logic                  resValid,
    output wiscExecPkg::wiscWord  resData,
    output wiscExecPkg::regIdx    resDest,
    output logic                  resErr
);

    wiscExecPkg::wiscWord btrOut;
    logic                 illegal;

    always_comb begin
        for (int i = 0; i < `WISC_WORD_WIDTH; i++) begin
            btrOut[i] = eBtrSrc[`WISC_WORD_WIDTH-1-i];
        end
    end

    assign illegal = (eResultSel == `WISC_SEL_ILL);

    always_comb begin
        case (eResultSel)
            `WISC_SEL_EQ:  finalValue = wiscExecPkg::wiscWord'(eZero);
            `WISC_SEL_LT:  finalValue = wiscExecPkg::wiscWord'(eLtz);
            `WISC_SEL_LE:  finalValue = wiscExecPkg::wiscWord'(eZero | eLtz);
            `WISC_SEL_CO:  finalValue = wiscExecPkg::wiscWord'(eCarry);
            `WISC_SEL_BTR: finalValue = btrOut;
            `WISC_SEL_ILL: finalValue = '0;
            default:       finalValue = eAluOut;
        endcase
    end

    // Register write lands on the same edge as the result register load
    assign wrEn   = advance && eValid && eWrites;
    assign wrAddr = eDest;
    assign wrData = finalValue;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            rValid <= 1'b0;
        end else if (advance) begin
            rValid <= eValid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            resData <= finalValue;
            rDest   <= eDest;
            rWrites <= eWrites;
            resErr  <= illegal || (eIsAddSub && eOvf);
        end
    end

    assign resValid = rValid;
    assign resDest  = rDest;

endmodule

// File: hdl/wiscExecTop.sv
// Top level of the WISC-SP20 execute unit
// Register file, decode, execute and result stages
// Pipeline-wide stall control from the output handshake
`timescale 1ns/10ps

module wiscExecTop (
    input  logic                 clk,
    input  logic                 arstN,
    input  logic                 instrValid,
    output logic                 instrReady,
    input  wiscExecPkg::wiscWord instr,
    output logic                 resValid,
    input  logic                 resReady,
    output wiscExecPkg::wiscWord resData,
    output wiscExecPkg::regIdx   resDest,
    output logic                 resErr
);

    logic                  advance;

    // Register file ports
    wiscExecPkg::regIdx    rdAddrA, rdAddrB, wrAddr;
    wiscExecPkg::wiscWord  rdDataA, rdDataB, wrData;
    logic                  wrEn;

    // Decode register
    logic                  dValid, dUseRegA, dUseRegB, dInvA, dInvB, dCin;
    logic                  dIsLbi, dIsSlbi, dIsAddSub, dWrites;
    wiscExecPkg::aluFunc   dFunc;
    wiscExecPkg::wiscWord  dOperandA, dOperandB;
    wiscExecPkg::regIdx    dSrcA, dSrcB, dDest;
    wiscExecPkg::resultSel dResultSel;

    // Execute register
    logic                  eValid, eZero, eLtz, eCarry, eOvf, eIsAddSub, eWrites;
    wiscExecPkg::wiscWord  eAluOut, eBtrSrc;
    wiscExecPkg::resultSel eResultSel;
    wiscExecPkg::regIdx    eDest;

    // Forwarding from the result stage
    wiscExecPkg::wiscWord  finalValue;
    logic                  rValid, rWrites;
    wiscExecPkg::regIdx    rDest;

    // Whole pipeline moves only when the output slot is free or drains
    assign advance    = !resValid || resReady;
    assign instrReady = advance;

    regFile regFile_inst (.*);

    decodeStage decodeStage_inst (.*);

    executeStage executeStage_inst (.*);

    resultStage resultStage_inst (.*);

endmodule

// File: tests/clockGen.sv
// Clock and reset generator of the testbench
// 4 ns clock, active low reset held for the first two cycles
`timescale 1ns/10ps

module clockGen #(
    parameter int HalfPeriod  = 2,
    parameter int ResetCycles = 2
) (
    output logic clk,
    output logic arstN
);

    initial begin
        clk = 1'b0;
        forever #(HalfPeriod) clk = ~clk;
    end

    // Release falls on a falling edge, away from the sampling edge
    initial begin
        arstN = 1'b0;
        #(2 * HalfPeriod * ResetCycles);
        arstN = 1'b1;
    end

endmodule

// File: tests/wiscExecTb.sv
// Testbench of the WISC-SP20 execute unit
// Directed and random instruction stream with valid gaps and output stalls
// Reference model, in-order comparison, latency check and timeout
`timescale 1ns/10ps
`include "wiscExec_defines.svh"

module wiscExecTb;

    localparam int NumInstr      = 400;
    localparam int TimeoutCycles = NumInstr * 8 + 100;
    localparam int Width         = `WISC_WORD_WIDTH;

    logic                 clk, arstN;
    logic                 instrValid, instrReady, resValid, resErr;
    logic                 resReady = 1'b0;
    wiscExecPkg::wiscWord instr, resData;
    wiscExecPkg::regIdx   resDest;

    int   seed       = 54686;
    int   cycleCount = 0;
    int   stallCount = 0;
    int   issued     = 0;
    int   sentCount  = 0;
    int   recvCount  = 0;
    logic stallMode  = 1'b0;
    logic gapMode    = 1'b0;

    // Model state and the expected results in acceptance order
    wiscExecPkg::wiscWord modelRegs [`WISC_REG_COUNT] = '{default: '0};
    wiscExecPkg::wiscWord expData [$];
    wiscExecPkg::regIdx   expDest [$];
    logic                 expErr [$];
    int                   expCycle [$];
    int                   expStall [$];

    wiscExecPkg::opcodeField legalOps [17] = '{
        `WISC_OP_ADDI, `WISC_OP_SUBI, `WISC_OP_XORI, `WISC_OP_ANDNI,
        `WISC_OP_ROLI, `WISC_OP_SLLI, `WISC_OP_RORI, `WISC_OP_SRLI,
        `WISC_OP_RALU, `WISC_OP_RSHIFT, `WISC_OP_SEQ, `WISC_OP_SLT,
        `WISC_OP_SLE, `WISC_OP_SCO, `WISC_OP_BTR, `WISC_OP_LBI, `WISC_OP_SLBI
    };

    clockGen clockGen_inst (.clk(clk), .arstN(arstN));

    wiscExecTop wiscExecTop_inst (.*);

    task automatic abortRun();
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic checkData(input wiscExecPkg::wiscWord got, input wiscExecPkg::wiscWord exp);
        if (got !== exp) begin
            $display("Error: resData got 0x%h, expected 0x%h", got, exp);
            abortRun();
        end
    endtask

    task automatic checkDest(input wiscExecPkg::regIdx got, input wiscExecPkg::regIdx exp);
        if (got !== exp) begin
            $display("Error: resDest got 0x%h, expected 0x%h", got, exp);
            abortRun();
        end
    endtask

    task automatic checkErr(input logic got, input logic exp);
        if (got !== exp) begin
            $display("Error: resErr got 0x%h, expected 0x%h", got, exp);
            abortRun();
        end
    endtask

    function automatic wiscExecPkg::wiscWord rotateLeft(input wiscExecPkg::wiscWord x,
                                                         input int n);
        wiscExecPkg::wiscWord r;
        r = x;
        for (int i = 0; i < n; i++) begin
            r = {r[Width-2:0], r[Width-1]};
        end
        return r;
    endfunction

    function automatic wiscExecPkg::wiscWord bitReverse(input wiscExecPkg::wiscWord x);
        wiscExecPkg::wiscWord r;
        for (int i = 0; i < Width; i++) begin
            r[i] = x[Width-1-i];
        end
        return r;
    endfunction

    function automatic logic isLegal(input wiscExecPkg::opcodeField op);
        foreach (legalOps[i]) begin
            if (legalOps[i] == op) return 1'b1;
        end
        return 1'b0;
    endfunction

    function automatic wiscExecPkg::wiscWord iFormat(input wiscExecPkg::opcodeField op,
                                                      input int rs, input int rt, input int imm);
        return {op, 3'(rs), 3'(rt), 5'(imm)};
    endfunction

    function automatic wiscExecPkg::wiscWord rFormat(input wiscExecPkg::opcodeField op,
                                                      input int rs, input int rt,
                                                      input int rd, input int fn);
        return {op, 3'(rs), 3'(rt), 3'(rd), 2'(fn)};
    endfunction

    function automatic wiscExecPkg::wiscWord byteFormat(input wiscExecPkg::opcodeField op,
                                                         input int rs, input int imm);
        return {op, 3'(rs), 8'(imm)};
    endfunction

    // Mostly legal opcodes with about one in sixteen illegal
    function automatic wiscExecPkg::wiscWord randomInstr();
        wiscExecPkg::opcodeField op;
        op = legalOps[$unsigned($random(seed)) % 17];
        if (($random(seed) & 15) == 0) begin
            do op = wiscExecPkg::opcodeField'($random(seed)); while (isLegal(op));
        end
        return {op, 11'($random(seed))};
    endfunction

    // Sequential reference of one instruction against the model registers
    function automatic void wiscModel(input wiscExecPkg::wiscWord ins,
                                      output wiscExecPkg::wiscWord data,
                                      output wiscExecPkg::regIdx dest,
                                      output logic err);
        wiscExecPkg::wiscWord a, b, immZ5;
        wiscExecPkg::regIdx   rs, rt, rd;
        int                   sa, sb, sImm, wide;
        logic                 arith, writes;
        rs     = ins[10:8];
        rt     = ins[7:5];
        rd     = ins[4:2];
        a      = modelRegs[rs];
        b      = modelRegs[rt];
        sa     = $signed(a);
        sb     = $signed(b);
        sImm   = $signed(ins[4:0]);
        immZ5  = wiscExecPkg::wiscWord'(ins[4:0]);
        wide   = 0;
        arith  = 1'b0;
        writes = 1'b1;
        data   = '0;
        err    = 1'b0;
        dest   = rt;
        case (wiscExecPkg::opcodeField'(ins[15:11]))
            `WISC_OP_ADDI: begin
                wide  = sa + sImm;
                arith = 1'b1;
            end
            `WISC_OP_SUBI: begin
                wide  = sImm - sa;
                arith = 1'b1;
            end
            `WISC_OP_XORI:  data = a ^ immZ5;
            `WISC_OP_ANDNI: data = a & ~immZ5;
            `WISC_OP_ROLI:  data = rotateLeft(a, ins[3:0]);
            `WISC_OP_SLLI:  data = a << ins[3:0];
            `WISC_OP_RORI:  data = rotateLeft(a, Width - ins[3:0]);
            `WISC_OP_SRLI:  data = a >> ins[3:0];
            `WISC_OP_RALU: begin
                dest  = rd;
                arith = (ins[1] == 1'b0);
                case (ins[1:0])
                    2'b00: wide = sa + sb;
                    2'b01: wide = sb - sa;
                    2'b10: data = a ^ b;
                    default: data = a & ~b;
                endcase
            end
            `WISC_OP_RSHIFT: begin
                dest = rd;
                case (ins[1:0])
                    2'b00: data = rotateLeft(a, b[3:0]);
                    2'b01: data = a << b[3:0];
                    2'b10: data = rotateLeft(a, Width - b[3:0]);
                    default: data = a >> b[3:0];
                endcase
            end
            `WISC_OP_SEQ: begin
                dest = rd;
                data = wiscExecPkg::wiscWord'(a == b);
            end
            `WISC_OP_SLT: begin
                dest = rd;
                data = wiscExecPkg::wiscWord'(sa < sb);
            end
            `WISC_OP_SLE: begin
                dest = rd;
                data = wiscExecPkg::wiscWord'(sa <= sb);
            end
            `WISC_OP_SCO: begin
                dest = rd;
                data = wiscExecPkg::wiscWord'(int'(a) + int'(b) > 65535);
            end
            `WISC_OP_BTR: begin
                dest = rd;
                data = bitReverse(a);
            end
            `WISC_OP_LBI: begin
                dest = rs;
                sImm = $signed(ins[7:0]);
                data = wiscExecPkg::wiscWord'(sImm);
            end
            `WISC_OP_SLBI: begin
                dest = rs;
                data = (a << 8) | wiscExecPkg::wiscWord'(ins[7:0]);
            end
            // Illegal opcodes report the rt field as destination
            default: begin
                err    = 1'b1;
                writes = 1'b0;
            end
        endcase
        if (arith) begin
            data = wide[Width-1:0];
            err  = (wide > 32767) || (wide < -32768);
        end
        if (writes) modelRegs[dest] = data;
    endfunction

    task automatic sendInstr(input wiscExecPkg::wiscWord w);
        while (gapMode && ($random(seed) & 3) == 0) begin
            instrValid <= 1'b0;
            @(posedge clk);
        end
        instrValid <= 1'b1;
        instr      <= w;
        @(posedge clk);
        while (!instrReady) begin
            @(posedge clk);
        end
        issued++;
    endtask

    // Cycle and stall counters, timeout
    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (arstN && !instrReady) stallCount <= stallCount + 1;
        if (cycleCount >= TimeoutCycles) begin
            $display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
            abortRun();
        end
    end

    always @(posedge clk) begin
        resReady <= stallMode ? (($random(seed) & 3) != 0) : 1'b1;
    end

    // Record the expected result of each accepted instruction
    always @(posedge clk) begin
        wiscExecPkg::wiscWord d;
        wiscExecPkg::regIdx   r;
        logic                 e;
        if (arstN && instrValid && instrReady) begin
            wiscModel(instr, d, r, e);
            expData.push_back(d);
            expDest.push_back(r);
            expErr.push_back(e);
            expCycle.push_back(cycleCount);
            expStall.push_back(stallCount);
            sentCount++;
        end
    end

    // Each transfer takes three advancing edges after acceptance
    always @(posedge clk) begin
        int took, want;
        if (arstN && resValid && resReady) begin
            if (expData.size() == 0) begin
                $display("A result came out with no instruction waiting for it");
                abortRun();
            end else begin
                checkData(resData, expData.pop_front());
                checkDest(resDest, expDest.pop_front());
                checkErr(resErr, expErr.pop_front());
                took = cycleCount - expCycle.pop_front();
                want = 3 + stallCount - expStall.pop_front();
                if (took != want) begin
                    $display("Result %0d took %0d cycles instead of %0d", recvCount, took, want);
                    abortRun();
                end
                recvCount++;
            end
        end
    end

    initial begin
        instrValid = 1'b0;
        instr      = '0;
        @(posedge arstN);
        @(posedge clk);
        // Fill every register with an LBI and a dependent SLBI
        for (int r = 0; r < `WISC_REG_COUNT; r++) begin
            sendInstr(byteFormat(`WISC_OP_LBI, r, $random(seed)));
            sendInstr(byteFormat(`WISC_OP_SLBI, r, $random(seed)));
        end
        // Overflow and set corner cases with r1 = 0x7fff, r2 = 1, r0 = 0x8000
        sendInstr(byteFormat(`WISC_OP_LBI, 1, 8'h7f));
        sendInstr(byteFormat(`WISC_OP_SLBI, 1, 8'hff));
        sendInstr(byteFormat(`WISC_OP_LBI, 2, 1));
        sendInstr(byteFormat(`WISC_OP_LBI, 0, 8'h80));
        sendInstr(byteFormat(`WISC_OP_SLBI, 0, 0));
        sendInstr(rFormat(`WISC_OP_RALU, 1, 2, 3, 0));
        sendInstr(rFormat(`WISC_OP_RALU, 0, 2, 4, 1));
        sendInstr(iFormat(`WISC_OP_ADDI, 1, 5, 1));
        sendInstr(iFormat(`WISC_OP_SUBI, 0, 6, 0));
        sendInstr(rFormat(`WISC_OP_SCO, 0, 0, 7, 0));
        sendInstr(rFormat(`WISC_OP_SEQ, 1, 1, 7, 0));
        sendInstr(rFormat(`WISC_OP_SLE, 0, 1, 7, 0));
        // Illegal words, then a read of the register they name
        sendInstr(iFormat(5'b00000, 3, 2, 5));
        sendInstr(iFormat(5'b01100, 1, 2, 9));
        sendInstr(iFormat(`WISC_OP_ADDI, 2, 7, 0));
        // Dependent chains at distance one and two on both operands
        for (int i = 0; i < 10; i++) begin
            sendInstr(iFormat(`WISC_OP_ADDI, 3, 3, i + 1));
            sendInstr(rFormat(`WISC_OP_RALU, 4, 3, 4, 2));
            sendInstr(rFormat(`WISC_OP_BTR, 3, 0, 5, 0));
            sendInstr(rFormat(`WISC_OP_RALU, 5, 4, 6, 3));
        end
        while (issued < NumInstr) begin
            if (issued == 160) begin
                gapMode = 1'b1;
                stallMode <= 1'b1;
            end
            sendInstr(randomInstr());
        end
        instrValid <= 1'b0;
        stallMode  <= 1'b0;
        while (recvCount < NumInstr) begin
            @(posedge clk);
        end
        // A few idle cycles expose any duplicated result
        repeat (8) @(posedge clk);
        if (sentCount == NumInstr && recvCount == NumInstr && expData.size() == 0) begin
            $display("Testbench passed");
            $finish;
        end else begin
            $display("Counts differ: %0d sent, %0d received", sentCount, recvCount);
            abortRun();
        end
    end

endmodule

// File: wiscExecTop.f
+incdir+hdl
hdl/wiscExecPkg.sv
hdl/regFile.sv
hdl/decodeStage.sv
hdl/executeStage.sv
hdl/resultStage.sv
hdl/wiscExecTop.sv
tests/clockGen.sv
tests/wiscExecTb.sv

// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = wiscExecTb
FILELIST = wiscExecTop.f
BUILD    = build

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   Build with Verilator and run the simulation"
	@echo "  clean  Remove the build directory"
	@echo "  help   List these targets"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD) -f $(FILELIST)
	./$(BUILD)/V$(TOP)

clean:
	rm -rf $(BUILD)
